// ==== design/inv_macros.svh ====
/*
 * Invaders I/O shared constants
 * Download stream index values, DIP bank size and CPU port width
 */
`ifndef INV_MACROS_SVH
`define INV_MACROS_SVH

// Download stream indices
`define INV_DL_INDEX_ROM  8'd0
`define INV_DL_INDEX_GAME 8'd1
`define INV_DL_INDEX_DIP  8'd254

// Number of DIP switch bytes kept from the download
`define INV_DIP_BYTES 4

// Width of one CPU input or output port
`define INV_PORT_W 8

`endif

// ==== design/inv_input_pkg.sv ====
/*
 * Invaders input types
 * PS/2 key events, joystick words and decoded player controls
 */
package inv_input_pkg;

	// PS/2 event, toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// Joystick word, bit 0 is right
	typedef struct packed {
		logic [4:0] unused_hi;
		logic       coin;
		logic       start2;
		logic       start1;
		logic [2:0] unused_lo;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire;
	} player_ctrl_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} sys_btn_t;

	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
		sys_btn_t     sys;
	} kbd_state_t;

endpackage

// ==== design/inv_machine_pkg.sv ====
/*
 * Invaders machine types
 * Game ids, CPU input port bytes, write triggers and board profile
 */
`include "inv_macros.svh"

package inv_machine_pkg;

	// Game ids as written by the download stream
	typedef enum logic [7:0] {
		GAME_INVADERS = 8'd0,
		GAME_VORTEX   = 8'd2,
		GAME_BOOTHILL = 8'd5,
		GAME_MAZE     = 8'd14
	} game_e;

	// CPU input port bytes
	typedef struct packed {
		logic [`INV_PORT_W-1:0] gdb0;
		logic [`INV_PORT_W-1:0] gdb1;
		logic [`INV_PORT_W-1:0] gdb2;
		logic [`INV_PORT_W-1:0] gdb3;
	} in_ports_t;

	// Strobes decoded from CPU port writes
	typedef struct packed {
		logic shift_count;
		logic shift_data;
		logic audio_p1;
		logic audio_p2;
		logic watchdog_reset;
	} triggers_t;

	typedef struct packed {
		logic landscape;
		logic ccw;
		logic wd_enabled;
	} profile_t;

	typedef logic [`INV_DIP_BYTES-1:0][`INV_PORT_W-1:0] dip_bank_t;

endpackage

// ==== design/ps2_key_decoder.sv ====
/*
 * PS/2 key decoder
 * Detects key events by toggle change and tracks pressed state of mapped keys
 */
`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  inv_input_pkg::ps2_key_t   key,
	output inv_input_pkg::kbd_state_t kbd
);

	logic                        toggle_q;
	logic                        key_event;
	inv_input_pkg::player_ctrl_t p1_q;
	inv_input_pkg::player_ctrl_t p2_q;
	logic                        start1_q;
	logic                        start2_q;
	// Two coin sources so one release leaves the other held
	logic                        coin_a_q;
	logic                        coin_b_q;

	assign key_event = key.toggle != toggle_q;

	////////////////////////////////////////////////////////////
	// Key state registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			toggle_q <= 1'b0;
			p1_q     <= '0;
			p2_q     <= '0;
			start1_q <= 1'b0;
			start2_q <= 1'b0;
			coin_a_q <= 1'b0;
			coin_b_q <= 1'b0;
		end
		else
		begin
			toggle_q <= key.toggle;
			if (key_event)
			begin
				case (key.code)
					// Player 1, arrows and left ctrl
					9'h075: p1_q.up    <= key.pressed;
					9'h072: p1_q.down  <= key.pressed;
					9'h06B: p1_q.left  <= key.pressed;
					9'h074: p1_q.right <= key.pressed;
					9'h014: p1_q.fire  <= key.pressed;
					// Player 2, R F D G and A
					9'h02D: p2_q.up    <= key.pressed;
					9'h02B: p2_q.down  <= key.pressed;
					9'h023: p2_q.left  <= key.pressed;
					9'h034: p2_q.right <= key.pressed;
					9'h01C: p2_q.fire  <= key.pressed;
					// F1/1, F2/2
					9'h005, 9'h016: start1_q <= key.pressed;
					9'h006, 9'h01E: start2_q <= key.pressed;
					// ESC has its own coin source, 5 and 6 share the other
					9'h076: coin_a_q <= key.pressed;
					9'h02E, 9'h036: coin_b_q <= key.pressed;
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		kbd.p1         = p1_q;
		kbd.p2         = p2_q;
		kbd.sys.start1 = start1_q;
		kbd.sys.start2 = start2_q;
		kbd.sys.coin   = coin_a_q | coin_b_q;
	end

	// Key state only moves on an event
	a_kbd_stable: assert property (@(posedge clk_sys) disable iff (rst)
		!key_event |=> $stable(kbd));

endmodule

// ==== design/download_capture.sv ====
/*
 * Download capture
 * Picks the game id and DIP switch bytes out of the download byte stream
 */
`timescale 1ns/1ps
`include "inv_macros.svh"

module download_capture (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       dl_wr,
	input  logic [7:0]                 dl_index,
	input  logic [15:0]                dl_addr,
	input  logic [7:0]                 dl_data,
	output inv_machine_pkg::game_e     game,
	output inv_machine_pkg::dip_bank_t dips
);

	localparam int DIP_AW = $clog2(`INV_DIP_BYTES);

	logic game_wr;
	logic dip_wr;

	assign game_wr = dl_wr && (dl_index == `INV_DL_INDEX_GAME);
	assign dip_wr  = dl_wr && (dl_index == `INV_DL_INDEX_DIP) && (dl_addr < `INV_DIP_BYTES);

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			game <= inv_machine_pkg::GAME_INVADERS;
			dips <= '0;
		end
		else
		begin
			if (game_wr)
				game <= inv_machine_pkg::game_e'(dl_data);
			if (dip_wr)
				dips[dl_addr[DIP_AW-1:0]] <= dl_data;
		end
	end

	a_one_target: assert property (@(posedge clk_sys) disable iff (rst)
		!(game_wr && dip_wr));

endmodule

// ==== design/port_mapper.sv ====
/*
 * Port mapper
 * Merges keyboard and joystick controls and builds the four CPU input
 * port bytes and the board profile for the selected game
 */
`timescale 1ns/1ps
`include "inv_macros.svh"

module port_mapper (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  inv_input_pkg::kbd_state_t  kbd,
	input  inv_input_pkg::joy_t        joy1,
	input  inv_input_pkg::joy_t        joy2,
	input  inv_machine_pkg::game_e     game,
	input  inv_machine_pkg::dip_bank_t dips,
	input  logic [`INV_PORT_W-1:0]     s,
	output inv_machine_pkg::in_ports_t ports,
	output inv_machine_pkg::profile_t  profile
);

	// Space Invaders bytes with idle inputs and zero DIPs
	localparam inv_machine_pkg::in_ports_t PORTS_RST = '{
		gdb0: 8'h8F, gdb1: 8'h88, gdb2: 8'h83, gdb3: 8'h00};
	localparam inv_machine_pkg::profile_t PROFILE_RST = '{
		landscape: 1'b0, ccw: 1'b1, wd_enabled: 1'b1};

	function automatic inv_input_pkg::player_ctrl_t joy_ctrl(inv_input_pkg::joy_t j);
		inv_input_pkg::player_ctrl_t c;
		c.right = j.right;
		c.left  = j.left;
		c.down  = j.down;
		c.up    = j.up;
		c.fire  = j.fire;
		return c;
	endfunction

	// Boot Hill uses the same layout for both players
	function automatic logic [7:0] boothill_byte(inv_input_pkg::player_ctrl_t c);
		return {c.fire, 3'b010, c.right, c.left, c.down, c.up};
	endfunction

	inv_input_pkg::player_ctrl_t p1;
	inv_input_pkg::player_ctrl_t p2;
	logic r, l, f;
	logic st1, st2, coin;
	inv_machine_pkg::in_ports_t ports_d;
	inv_machine_pkg::profile_t  profile_d;

	assign p1   = kbd.p1 | joy_ctrl(joy1);
	assign p2   = kbd.p2 | joy_ctrl(joy2);
	assign r    = p1.right | p2.right;
	assign l    = p1.left | p2.left;
	assign f    = p1.fire | p2.fire;
	assign st1  = kbd.sys.start1 | joy1.start1 | joy2.start1;
	assign st2  = kbd.sys.start2 | joy1.start2 | joy2.start2;
	assign coin = kbd.sys.coin | joy1.coin | joy2.coin;

	////////////////////////////////////////////////////////////
	// Per-game port layout
	////////////////////////////////////////////////////////////
	always_comb
	begin
		ports_d   = '{gdb0: 8'hFF, gdb1: 8'hFF, gdb2: 8'hFF, gdb3: s};
		profile_d = '{landscape: 1'b1, ccw: 1'b0, wd_enabled: 1'b1};
		case (game)
			inv_machine_pkg::GAME_INVADERS:
			begin
				ports_d.gdb0 = dips[0] | {1'b1, r, l, f, 4'b1111};
				ports_d.gdb1 = dips[1] | {1'b1, r, l, f, 1'b1, st1, st2, coin};
				ports_d.gdb2 = dips[2] | {1'b1, r, l, f, 4'b0011};
				profile_d    = PROFILE_RST;
			end
			inv_machine_pkg::GAME_VORTEX:
			begin
				ports_d.gdb1 = s;
				ports_d.gdb2 = dips[1] | {1'b1, p1.right, p1.left, p1.fire, 1'b1, st1, st2, coin};
				ports_d.gdb3 = dips[2] | {1'b0, p2.right, p2.left, p2.fire, 4'b0000};
				profile_d    = PROFILE_RST;
			end
			inv_machine_pkg::GAME_BOOTHILL:
			begin
				ports_d.gdb0 = dips[0] | boothill_byte(p1);
				ports_d.gdb1 = dips[1] | boothill_byte(p2);
				ports_d.gdb2 = dips[2] | {st1, coin, st1, 5'b01101};
			end
			inv_machine_pkg::GAME_MAZE:
			begin
				ports_d.gdb0 = dips[0] | {p2.up, p2.down, p2.right, p2.left,
					p1.up, p1.down, p1.right, p1.left};
				ports_d.gdb1 = dips[1] | {4'b0000, coin, 1'b0, st2, st1};
				ports_d.gdb2 = 8'h00;
				profile_d.wd_enabled = 1'b0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			ports   <= PORTS_RST;
			profile <= PROFILE_RST;
		end
		else
		begin
			ports   <= ports_d;
			profile <= profile_d;
		end
	end

	// Watchdog is only ever disabled for the maze game
	a_wd_maze_only: assert property (@(posedge clk_sys) disable iff (rst)
		!profile.wd_enabled |-> $past(game) == inv_machine_pkg::GAME_MAZE);

endmodule

// ==== design/trigger_router.sv ====
/*
 * Trigger router
 * Selects the CPU port-write strobes that drive shifter, audio and watchdog
 */
`timescale 1ns/1ps
`include "inv_macros.svh"

module trigger_router (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic [`INV_PORT_W-1:0]     port_wr,
	input  inv_machine_pkg::game_e     game,
	output inv_machine_pkg::triggers_t triggers
);

	inv_machine_pkg::triggers_t trig_d;

	always_comb
	begin
		// Space Invaders wiring, also the fallback
		trig_d.shift_count    = port_wr[2];
		trig_d.audio_p1       = port_wr[3];
		trig_d.shift_data     = port_wr[4];
		trig_d.audio_p2       = port_wr[5];
		trig_d.watchdog_reset = port_wr[6];
		case (game)
			inv_machine_pkg::GAME_VORTEX:
			begin
				trig_d.shift_count    = port_wr[0];
				trig_d.audio_p1       = port_wr[1];
				trig_d.shift_data     = port_wr[6];
				trig_d.audio_p2       = port_wr[7];
				trig_d.watchdog_reset = port_wr[4];
			end
			inv_machine_pkg::GAME_BOOTHILL:
			begin
				trig_d.shift_count    = port_wr[1];
				trig_d.audio_p1       = port_wr[3];
				trig_d.shift_data     = port_wr[2];
				// No second audio board
				trig_d.audio_p2       = 1'b0;
				trig_d.watchdog_reset = port_wr[4];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (rst)
			triggers <= '0;
		else
			triggers <= trig_d;
	end

	a_no_p2_boothill: assert property (@(posedge clk_sys) disable iff (rst)
		triggers.audio_p2 |-> $past(game) != inv_machine_pkg::GAME_BOOTHILL);

endmodule

// ==== design/invaders_io_top.sv ====
/*
 * Invaders I/O top
 * Key decoder and download capture feed the port mapper; CPU port writes
 * go through the trigger router
 */
`timescale 1ns/1ps
`include "inv_macros.svh"

module invaders_io_top (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  inv_input_pkg::ps2_key_t    key,
	input  inv_input_pkg::joy_t        joy1,
	input  inv_input_pkg::joy_t        joy2,
	input  logic                       dl_wr,
	input  logic [7:0]                 dl_index,
	input  logic [15:0]                dl_addr,
	input  logic [7:0]                 dl_data,
	input  logic [`INV_PORT_W-1:0]     port_wr,
	input  logic [`INV_PORT_W-1:0]     s,
	output inv_machine_pkg::in_ports_t ports,
	output inv_machine_pkg::profile_t  profile,
	output inv_machine_pkg::triggers_t triggers
);

	inv_input_pkg::kbd_state_t  kbd;
	inv_machine_pkg::game_e     game;
	inv_machine_pkg::dip_bank_t dips;

	////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////
	ps2_key_decoder u_key_decoder (
		.clk_sys (clk_sys),
		.rst     (rst),
		.key     (key),
		.kbd     (kbd)
	);

	download_capture u_download_capture (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dips     (dips)
	);

	////////////////////////////////////////////////////////////
	// Port bytes and write strobes
	////////////////////////////////////////////////////////////
	port_mapper u_port_mapper (
		.clk_sys (clk_sys),
		.rst     (rst),
		.kbd     (kbd),
		.joy1    (joy1),
		.joy2    (joy2),
		.game    (game),
		.dips    (dips),
		.s       (s),
		.ports   (ports),
		.profile (profile)
	);

	trigger_router u_trigger_router (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.port_wr  (port_wr),
		.game     (game),
		.triggers (triggers)
	);

endmodule

// ==== test/tb_invaders_io.sv ====
/*
 * Invaders I/O testbench
 * Directed tests for key decoding, downloads, per-game port bytes and triggers
 */
`timescale 1ns/1ps
`include "inv_macros.svh"

module tb_invaders_io;

	localparam int CLK_PERIOD = 4;
	// Rough cycle budget of each test
	localparam int CYC_RESET = 8;
	localparam int CYC_KEYS = 100;
	localparam int CYC_VORTEX = 30;
	localparam int CYC_DIP = 50;
	localparam int CYC_TRIG = 250;
	localparam int CYC_MAZE = 100;
	localparam int CYC_ALL = CYC_RESET + CYC_KEYS + CYC_VORTEX + CYC_DIP + CYC_TRIG + CYC_MAZE;
	localparam int WATCHDOG_NS = (2 * CYC_ALL + 100) * CLK_PERIOD;

	localparam logic [8:0] MAPPED_KEYS [0:16] = '{9'h075, 9'h072, 9'h06B, 9'h074, 9'h014,
		9'h02D, 9'h02B, 9'h023, 9'h034, 9'h01C, 9'h005, 9'h016, 9'h006, 9'h01E,
		9'h076, 9'h02E, 9'h036};
	localparam logic [7:0] KEPT_GAMES [0:3] = '{8'd0, 8'd2, 8'd5, 8'd14};

	logic                       clk_sys;
	logic                       rst;
	inv_input_pkg::ps2_key_t    key;
	inv_input_pkg::joy_t        joy1;
	inv_input_pkg::joy_t        joy2;
	logic                       dl_wr;
	logic [7:0]                 dl_index;
	logic [15:0]                dl_addr;
	logic [7:0]                 dl_data;
	logic [7:0]                 port_wr;
	logic [7:0]                 s;
	inv_machine_pkg::in_ports_t ports;
	inv_machine_pkg::profile_t  profile;
	inv_machine_pkg::triggers_t triggers;

	// Reference state, bit 0 right, 1 left, 2 down, 3 up, 4 fire
	logic [4:0] kp1;
	logic [4:0] kp2;
	logic       kst1;
	logic       kst2;
	logic       kcoin_a;
	logic       kcoin_b;
	logic [7:0] mgame;
	logic [7:0] mdip [0:3];

	integer      seed;
	logic [31:0] rnd;
	int          check_count;
	int          fail_count;

	invaders_io_top dut_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.key      (key),
		.joy1     (joy1),
		.joy2     (joy2),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.port_wr  (port_wr),
		.s        (s),
		.ports    (ports),
		.profile  (profile),
		.triggers (triggers)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] model_ports(input logic [7:0] g);
		logic [4:0] a;
		logic [4:0] b;
		logic       r, l, f, st1, st2, cn;
		logic [7:0] d0, d1, d2, d3;
		a = kp1 | joy1[4:0];
		b = kp2 | joy2[4:0];
		r = a[0] | b[0];
		l = a[1] | b[1];
		f = a[4] | b[4];
		st1 = kst1 | joy1[8] | joy2[8];
		st2 = kst2 | joy1[9] | joy2[9];
		cn = kcoin_a | kcoin_b | joy1[10] | joy2[10];
		d0 = 8'hFF;
		d1 = 8'hFF;
		d2 = 8'hFF;
		d3 = s;
		case (g)
			8'd0:
			begin
				d0 = mdip[0] | {1'b1, r, l, f, 4'b1111};
				d1 = mdip[1] | {1'b1, r, l, f, 1'b1, st1, st2, cn};
				d2 = mdip[2] | {1'b1, r, l, f, 4'b0011};
			end
			8'd2:
			begin
				d1 = s;
				d2 = mdip[1] | {1'b1, a[0], a[1], a[4], 1'b1, st1, st2, cn};
				d3 = mdip[2] | {1'b0, b[0], b[1], b[4], 4'b0000};
			end
			8'd5:
			begin
				d0 = mdip[0] | {a[4], 3'b010, a[0], a[1], a[2], a[3]};
				d1 = mdip[1] | {b[4], 3'b010, b[0], b[1], b[2], b[3]};
				d2 = mdip[2] | {st1, cn, st1, 5'b01101};
			end
			8'd14:
			begin
				d0 = mdip[0] | {b[3], b[2], b[0], b[1], a[3], a[2], a[0], a[1]};
				d1 = mdip[1] | {4'b0000, cn, 1'b0, st2, st1};
				d2 = 8'h00;
			end
			default: ;
		endcase
		return {d0, d1, d2, d3};
	endfunction

	// landscape, ccw, wd_enabled
	function automatic logic [2:0] model_profile(input logic [7:0] g);
		if (g == 8'd0 || g == 8'd2)
			return 3'b011;
		if (g == 8'd14)
			return 3'b100;
		return 3'b101;
	endfunction

	// shift_count, shift_data, audio_p1, audio_p2, watchdog_reset
	function automatic logic [4:0] model_trig(input logic [7:0] g, input logic [7:0] pw);
		if (g == 8'd2)
			return {pw[0], pw[6], pw[1], pw[7], pw[4]};
		if (g == 8'd5)
			return {pw[1], pw[2], pw[3], 1'b0, pw[4]};
		return {pw[2], pw[4], pw[3], pw[5], pw[6]};
	endfunction

	task automatic apply_key(input logic [8:0] code, input logic p);
		case (code)
			9'h075: kp1[3] = p;
			9'h072: kp1[2] = p;
			9'h06B: kp1[1] = p;
			9'h074: kp1[0] = p;
			9'h014: kp1[4] = p;
			9'h02D: kp2[3] = p;
			9'h02B: kp2[2] = p;
			9'h023: kp2[1] = p;
			9'h034: kp2[0] = p;
			9'h01C: kp2[4] = p;
			9'h005, 9'h016: kst1 = p;
			9'h006, 9'h01E: kst2 = p;
			9'h076: kcoin_a = p;
			9'h02E, 9'h036: kcoin_b = p;
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			fail_count++;
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_outputs(input string tag);
		check_value({tag, " ports"}, 32'(ports), model_ports(mgame));
		check_value({tag, " profile"}, 32'(profile), 32'(model_profile(mgame)));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("%-20s %0d mismatches", name, fail_count - fails_before);
	endtask

	// New event, checked two cycles later
	task automatic send_key(input logic [8:0] code, input logic p);
		key.toggle = ~key.toggle;
		key.pressed = p;
		key.code = code;
		apply_key(code, p);
		wait_cycles(2);
		check_outputs($sformatf("key %h pressed %b", code, p));
	endtask

	// Write strobe plus one cycle so ports have caught up
	task automatic download(input logic [7:0] idx, input logic [15:0] addr, input logic [7:0] data);
		dl_wr = 1'b1;
		dl_index = idx;
		dl_addr = addr;
		dl_data = data;
		if (idx == `INV_DL_INDEX_GAME)
			mgame = data;
		if (idx == `INV_DL_INDEX_DIP && addr < `INV_DIP_BYTES)
			mdip[addr[1:0]] = data;
		wait_cycles(1);
		dl_wr = 1'b0;
		wait_cycles(1);
	endtask

	task automatic pulse_port_write(input logic [7:0] pw, input int len);
		port_wr = pw;
		repeat (len)
		begin
			wait_cycles(1);
			check_value($sformatf("triggers game %0d port_wr %h", mgame, pw),
				32'(triggers), 32'(model_trig(mgame, pw)));
		end
		port_wr = 8'h00;
		wait_cycles(1);
		check_value("triggers after strobe", 32'(triggers), 32'd0);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic reset_values();
		int fb;
		fb = fail_count;
		wait_cycles(1);
		check_value("triggers after reset", 32'(triggers), 32'd0);
		check_value("profile after reset", 32'(profile), 32'(3'b011));
		check_outputs("reset");
		report_test("reset_values", fb);
	endtask

	task automatic keyboard_events();
		int fb;
		int i;
		fb = fail_count;
		for (i = 0; i < 17; i++)
		begin
			send_key(MAPPED_KEYS[i], 1'b1);
			send_key(MAPPED_KEYS[i], 1'b0);
		end
		send_key(9'h0AA, 1'b1);
		// Same toggle again is no event
		key.pressed = 1'b1;
		key.code = 9'h074;
		wait_cycles(2);
		check_outputs("repeated toggle");
		send_key(9'h076, 1'b1);
		send_key(9'h02E, 1'b1);
		send_key(9'h076, 1'b0);
		check_value("coin held by second key", 32'(ports.gdb1[0]), 32'd1);
		send_key(9'h02E, 1'b0);
		report_test("keyboard_events", fb);
	endtask

	task automatic vortex_joysticks();
		int fb;
		int i;
		fb = fail_count;
		download(`INV_DL_INDEX_GAME, 16'd0, 8'd2);
		check_outputs("vortex selected");
		for (i = 0; i < 12; i++)
		begin
			rnd = $random(seed);
			joy1 = rnd[15:0];
			joy2 = rnd[31:16];
			rnd = $random(seed);
			s = rnd[7:0];
			wait_cycles(1);
			check_outputs($sformatf("vortex joy %h %h s %h", joy1, joy2, s));
		end
		joy1 = '0;
		joy2 = '0;
		report_test("vortex_joysticks", fb);
	endtask

	task automatic dip_bank_boothill();
		int fb;
		int k;
		fb = fail_count;
		download(`INV_DL_INDEX_GAME, 16'd0, 8'd5);
		for (k = 0; k < `INV_DIP_BYTES; k++)
		begin
			rnd = $random(seed);
			download(`INV_DL_INDEX_DIP, 16'(k), rnd[7:0]);
			check_outputs($sformatf("dip %0d", k));
		end
		rnd = $random(seed);
		joy1 = rnd[15:0];
		joy2 = rnd[31:16];
		wait_cycles(1);
		check_outputs("boothill joysticks");
		download(`INV_DL_INDEX_DIP, 16'd4, 8'hFF);
		download(`INV_DL_INDEX_DIP, 16'h0100, 8'h55);
		check_outputs("dip address out of range");
		download(`INV_DL_INDEX_ROM, 16'd1, 8'd14);
		check_outputs("rom index write");
		for (k = 0; k < `INV_DIP_BYTES; k++)
			download(`INV_DL_INDEX_DIP, 16'(k), 8'h00);
		joy1 = '0;
		joy2 = '0;
		report_test("dip_bank_boothill", fb);
	endtask

	task automatic trigger_routing();
		int fb;
		int g;
		int b;
		fb = fail_count;
		for (g = 0; g < 4; g++)
		begin
			download(`INV_DL_INDEX_GAME, 16'd0, KEPT_GAMES[g]);
			for (b = 0; b < 8; b++)
				pulse_port_write(8'h01 << b, 1);
			for (b = 0; b < 8; b++)
			begin
				rnd = $random(seed);
				pulse_port_write(rnd[7:0], int'(rnd[9:8]) + 1);
			end
		end
		report_test("trigger_routing", fb);
	endtask

	task automatic maze_and_unknown();
		int fb;
		int i;
		fb = fail_count;
		download(`INV_DL_INDEX_GAME, 16'd0, 8'd14);
		check_outputs("maze idle");
		// Maze bytes show up and down of each player on their own
		for (i = 0; i < 17; i++)
		begin
			send_key(MAPPED_KEYS[i], 1'b1);
			send_key(MAPPED_KEYS[i], 1'b0);
		end
		rnd = $random(seed);
		joy1 = rnd[15:0];
		joy2 = rnd[31:16];
		wait_cycles(1);
		check_outputs("maze joysticks");
		download(`INV_DL_INDEX_GAME, 16'd0, 8'd7);
		check_outputs("unknown game");
		joy1 = '0;
		joy2 = '0;
		report_test("maze_and_unknown", fb);
	endtask

	initial
	begin
		seed = 32'h6ade;
		check_count = 0;
		fail_count = 0;
		rst = 1'b1;
		key = '0;
		joy1 = '0;
		joy2 = '0;
		dl_wr = 1'b0;
		dl_index = 8'h00;
		dl_addr = 16'h0000;
		dl_data = 8'h00;
		port_wr = 8'h00;
		s = 8'h00;
		kp1 = '0;
		kp2 = '0;
		kst1 = 1'b0;
		kst2 = 1'b0;
		kcoin_a = 1'b0;
		kcoin_b = 1'b0;
		mgame = 8'd0;
		mdip = '{8'h00, 8'h00, 8'h00, 8'h00};
		wait_cycles(3);
		rst = 1'b0;

		reset_values();
		keyboard_events();
		vortex_joysticks();
		dip_bank_boothill();
		trigger_routing();
		maze_and_unknown();

		$display("Summary: %0d checks, %0d mismatches", check_count, fail_count);
		if (fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+design
design/inv_input_pkg.sv
design/inv_machine_pkg.sv
design/ps2_key_decoder.sv
design/download_capture.sv
design/port_mapper.sv
design/trigger_router.sv
design/invaders_io_top.sv
test/tb_invaders_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module tb_invaders_io -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^All checks passed$" sim.log
echo "Simulation passed"
